// File: common/csr_params.svh
/*
 * Sizes, CSR addresses and identity values for the CSR data block.
 * Counter width must stay between 33 and 64 bits for the high-half reads.
 */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_NUM_WARPS       4
`define CSR_NUM_THREADS     4
`define CSR_NUM_CORES       2
`define CSR_NUM_FPU_BLOCKS  2
`define CSR_CTR_BITS        44
`define CSR_FFLAGS_BITS     5
`define CSR_FRM_BITS        3
`define CSR_ADDR_BITS       12

`define CSR_VENDOR_ID       32'h0000_0101
`define CSR_ARCH_ID         32'h0000_0002
`define CSR_IMPL_ID         32'h0000_0003
// RV32 with I, M, A and F
`define CSR_MISA_VALUE      32'h4000_1121

// Floating-point CSRs
`define CSR_ADDR_FFLAGS     12'h001
`define CSR_ADDR_FRM        12'h002
`define CSR_ADDR_FCSR       12'h003

// Stubs, always read as zero
`define CSR_ADDR_SATP       12'h180
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_PMPCFG0    12'h3A0
`define CSR_ADDR_PMPADDR0   12'h3B0
`define CSR_ADDR_MNSTATUS   12'h744

// Identity, status and counters
`define CSR_ADDR_MISA        12'h301
`define CSR_ADDR_MCYCLE      12'hB00
`define CSR_ADDR_MINSTRET    12'hB02
`define CSR_ADDR_MCYCLE_H    12'hB80
`define CSR_ADDR_MINSTRET_H  12'hB82
`define CSR_ADDR_WARP_ID     12'hCC1
`define CSR_ADDR_CORE_ID     12'hCC2
`define CSR_ADDR_WARP_MASK   12'hCC3
`define CSR_ADDR_THREAD_MASK 12'hCC4
`define CSR_ADDR_MVENDORID   12'hF11
`define CSR_ADDR_MARCHID     12'hF12
`define CSR_ADDR_MIMPID      12'hF13
`define CSR_ADDR_NUM_THREADS 12'hFC0
`define CSR_ADDR_NUM_WARPS   12'hFC1
`define CSR_ADDR_NUM_CORES   12'hFC2

`endif

// File: common/csr_pkg.sv
/*
 * Shared types of the CSR data block, sized from csr_params.svh.
 */
`include "csr_params.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [$clog2(`CSR_NUM_WARPS)-1:0] warp_id_t;
    typedef logic [`CSR_FRM_BITS-1:0] frm_t;
    typedef logic [`CSR_CTR_BITS-1:0] counter_t;
    typedef logic [`CSR_NUM_THREADS-1:0] thread_mask_t;
    typedef logic [`CSR_NUM_WARPS-1:0] warp_mask_t;
    typedef logic [31:0] csr_word_t;

    // IEEE 754 accrued exceptions, invalid in the top bit
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    // Same layout as the fcsr CSR word
    typedef struct packed {
        frm_t    frm;
        fflags_t fflags;
    } fcsr_t;

endpackage

// File: fcsr/fcsr_regfile.sv
/*
 * Per-warp floating-point control registers.
 * FPU flags accrue first; a CSR write to the same field in the same cycle wins.
 * Reads of fflags, frm and fcsr decode here and return the old value.
 */
`timescale 1ns/1ps
`include "csr_params.svh"

module fcsr_regfile (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               write_enable,
    input  csr_pkg::warp_id_t                                  write_wid,
    input  csr_pkg::csr_addr_t                                 write_addr,
    input  csr_pkg::csr_word_t                                 write_data,
    input  logic [`CSR_NUM_FPU_BLOCKS-1:0]                     fpu_write_enable,
    input  csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]        fpu_write_wid,
    input  csr_pkg::fflags_t [`CSR_NUM_FPU_BLOCKS-1:0]         fpu_write_fflags,
    input  csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]        fpu_read_wid,
    output csr_pkg::frm_t [`CSR_NUM_FPU_BLOCKS-1:0]            fpu_read_frm,
    input  csr_pkg::warp_id_t                                  read_wid,
    input  csr_pkg::csr_addr_t                                 read_addr,
    output logic                                               rw_hit,
    output csr_pkg::csr_word_t                                 rw_data
);

    csr_pkg::fcsr_t [`CSR_NUM_WARPS-1:0] fcsr_q;
    csr_pkg::fcsr_t [`CSR_NUM_WARPS-1:0] fcsr_n;
    csr_pkg::fcsr_t                      rd_fcsr;

    always_comb begin
        fcsr_n = fcsr_q;
        // Two blocks naming one warp both accrue
        for (int i = 0; i < `CSR_NUM_FPU_BLOCKS; i++) begin
            if (fpu_write_enable[i]) begin
                fcsr_n[fpu_write_wid[i]].fflags = fcsr_n[fpu_write_wid[i]].fflags
                                                | fpu_write_fflags[i];
            end
        end
        if (write_enable) begin
            case (write_addr)
                `CSR_ADDR_FFLAGS: fcsr_n[write_wid].fflags = write_data[`CSR_FFLAGS_BITS-1:0];
                `CSR_ADDR_FRM:    fcsr_n[write_wid].frm = write_data[`CSR_FRM_BITS-1:0];
                `CSR_ADDR_FCSR:   fcsr_n[write_wid] = write_data[$bits(csr_pkg::fcsr_t)-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_q <= '0;
        end else begin
            fcsr_q <= fcsr_n;
        end
    end

    for (genvar i = 0; i < `CSR_NUM_FPU_BLOCKS; i++) begin : g_frm_port
        assign fpu_read_frm[i] = fcsr_q[fpu_read_wid[i]].frm;
    end

    assign rd_fcsr = fcsr_q[read_wid];

    always_comb begin
        rw_hit  = 1'b1;
        rw_data = '0;
        case (read_addr)
            `CSR_ADDR_FFLAGS: rw_data = 32'(rd_fcsr.fflags);
            `CSR_ADDR_FRM:    rw_data = 32'(rd_fcsr.frm);
            `CSR_ADDR_FCSR:   rw_data = 32'(rd_fcsr);
            default:          rw_hit = 1'b0;
        endcase
    end

endmodule

// File: hdl/csr_info_decode.sv
/*
 * Read-only identity, status and counter CSRs, plus the zero-reading stubs.
 * Purely combinational; ro_hit is low for any address not listed here.
 */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_info_decode #(
    parameter int core_id = 0
) (
    input  csr_pkg::warp_id_t                              read_wid,
    input  csr_pkg::csr_addr_t                             read_addr,
    input  csr_pkg::counter_t                              cycles,
    input  csr_pkg::counter_t                              instret,
    input  csr_pkg::warp_mask_t                            active_warps,
    input  csr_pkg::thread_mask_t [`CSR_NUM_WARPS-1:0]     thread_masks,
    output logic                                           ro_hit,
    output csr_pkg::csr_word_t                             ro_data
);

    always_comb begin
        ro_hit  = 1'b1;
        ro_data = '0;
        case (read_addr)
            // Identity
            `CSR_ADDR_MVENDORID:   ro_data = `CSR_VENDOR_ID;
            `CSR_ADDR_MARCHID:     ro_data = `CSR_ARCH_ID;
            `CSR_ADDR_MIMPID:      ro_data = `CSR_IMPL_ID;
            `CSR_ADDR_MISA:        ro_data = `CSR_MISA_VALUE;

            // Per-warp and per-core status
            `CSR_ADDR_WARP_ID:     ro_data = 32'(read_wid);
            `CSR_ADDR_CORE_ID:     ro_data = 32'(core_id);
            `CSR_ADDR_THREAD_MASK: ro_data = 32'(thread_masks[read_wid]);
            `CSR_ADDR_WARP_MASK:   ro_data = 32'(active_warps);
            `CSR_ADDR_NUM_THREADS: ro_data = 32'(`CSR_NUM_THREADS);
            `CSR_ADDR_NUM_WARPS:   ro_data = 32'(`CSR_NUM_WARPS);
            `CSR_ADDR_NUM_CORES:   ro_data = 32'(`CSR_NUM_CORES);

            // Counters split into low word and remaining high bits
            `CSR_ADDR_MCYCLE:      ro_data = cycles[31:0];
            `CSR_ADDR_MCYCLE_H:    ro_data = 32'(cycles[`CSR_CTR_BITS-1:32]);
            `CSR_ADDR_MINSTRET:    ro_data = instret[31:0];
            `CSR_ADDR_MINSTRET_H:  ro_data = 32'(instret[`CSR_CTR_BITS-1:32]);

            `CSR_ADDR_SATP,
            `CSR_ADDR_MSTATUS,
            `CSR_ADDR_MNSTATUS,
            `CSR_ADDR_MEDELEG,
            `CSR_ADDR_MIDELEG,
            `CSR_ADDR_MIE,
            `CSR_ADDR_MTVEC,
            `CSR_ADDR_MEPC,
            `CSR_ADDR_PMPCFG0,
            `CSR_ADDR_PMPADDR0:    ro_data = '0;

            default:               ro_hit = 1'b0;
        endcase
    end

endmodule

// File: hdl/csr_read_merge.sv
/*
 * Registers the read response one cycle after the request strobe.
 * The two hit inputs come from disjoint address sets and are never both high.
 * Data and error hold their value between requests.
 */
`timescale 1ns/1ps

module csr_read_merge (
    input  logic               clk,
    input  logic               reset,
    input  logic               read_enable,
    input  logic               ro_hit,
    input  logic               rw_hit,
    input  csr_pkg::csr_word_t ro_data,
    input  csr_pkg::csr_word_t rw_data,
    output logic               read_resp_valid,
    output csr_pkg::csr_word_t read_data,
    output logic               read_error
);

    logic               any_hit;
    csr_pkg::csr_word_t hit_data;

    assign any_hit  = ro_hit || rw_hit;
    assign hit_data = rw_hit ? rw_data : (ro_hit ? ro_data : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            read_resp_valid <= 1'b0;
            read_error      <= 1'b0;
        end else begin
            read_resp_valid <= read_enable;
            if (read_enable) begin
                read_error <= !any_hit;
            end
        end
    end

    // Unmapped address captures zero
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= hit_data;
        end
    end

endmodule

// File: hdl/csr_data.sv
/*
 * CSR data block of one core. One read and one write accepted every cycle,
 * no back-pressure. Read response is registered, one cycle after the request.
 */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_data #(
    parameter int core_id = 0
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           write_enable,
    input  csr_pkg::warp_id_t                              write_wid,
    input  csr_pkg::csr_addr_t                             write_addr,
    input  csr_pkg::csr_word_t                             write_data,
    input  logic [`CSR_NUM_FPU_BLOCKS-1:0]                 fpu_write_enable,
    input  csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]    fpu_write_wid,
    input  csr_pkg::fflags_t [`CSR_NUM_FPU_BLOCKS-1:0]     fpu_write_fflags,
    input  csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]    fpu_read_wid,
    output csr_pkg::frm_t [`CSR_NUM_FPU_BLOCKS-1:0]        fpu_read_frm,
    input  csr_pkg::counter_t                              cycles,
    input  csr_pkg::counter_t                              instret,
    input  csr_pkg::warp_mask_t                            active_warps,
    input  csr_pkg::thread_mask_t [`CSR_NUM_WARPS-1:0]     thread_masks,
    input  logic                                           read_enable,
    input  csr_pkg::warp_id_t                              read_wid,
    input  csr_pkg::csr_addr_t                             read_addr,
    output logic                                           read_resp_valid,
    output csr_pkg::csr_word_t                             read_data,
    output logic                                           read_error
);

    logic               rw_hit;
    logic               ro_hit;
    csr_pkg::csr_word_t rw_data;
    csr_pkg::csr_word_t ro_data;

    fcsr_regfile fcsr_regfile_inst (
        .clk              (clk),
        .reset            (reset),
        .write_enable     (write_enable),
        .write_wid        (write_wid),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .fpu_write_enable (fpu_write_enable),
        .fpu_write_wid    (fpu_write_wid),
        .fpu_write_fflags (fpu_write_fflags),
        .fpu_read_wid     (fpu_read_wid),
        .fpu_read_frm     (fpu_read_frm),
        .read_wid         (read_wid),
        .read_addr        (read_addr),
        .rw_hit           (rw_hit),
        .rw_data          (rw_data)
    );

    csr_info_decode #(
        .core_id (core_id)
    ) csr_info_decode_inst (
        .read_wid     (read_wid),
        .read_addr    (read_addr),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .ro_hit       (ro_hit),
        .ro_data      (ro_data)
    );

    csr_read_merge csr_read_merge_inst (
        .clk             (clk),
        .reset           (reset),
        .read_enable     (read_enable),
        .ro_hit          (ro_hit),
        .rw_hit          (rw_hit),
        .ro_data         (ro_data),
        .rw_data         (rw_data),
        .read_resp_valid (read_resp_valid),
        .read_data       (read_data),
        .read_error      (read_error)
    );

endmodule

// File: sim/csr_data_checker.sv
/*
 * Read response assertions, bound to every csr_data instance.
 * Assumes read_enable is held low while reset is high.
 */
`timescale 1ns/1ps

module csr_data_checker (
    input logic               clk,
    input logic               reset,
    input logic               read_enable,
    input logic               read_resp_valid,
    input csr_pkg::csr_word_t read_data,
    input logic               read_error
);

    int assert_failures = 0;

    // Quiet during reset and in the first cycle after it
    resp_quiet_in_reset: assert property (@(posedge clk) reset |=> !read_resp_valid)
        else begin
            $error("read_resp_valid high during or right after reset");
            assert_failures++;
        end

    resp_follows_request: assert property (
        @(posedge clk) disable iff (reset) read_resp_valid == $past(read_enable))
        else begin
            $error("read_resp_valid does not follow read_enable by one cycle");
            assert_failures++;
        end

    error_reads_zero: assert property (
        @(posedge clk) disable iff (reset) read_error |-> read_data == '0)
        else begin
            $error("read_error high with nonzero read_data");
            assert_failures++;
        end

endmodule

bind csr_data csr_data_checker checker_inst (
    .clk             (clk),
    .reset           (reset),
    .read_enable     (read_enable),
    .read_resp_valid (read_resp_valid),
    .read_data       (read_data),
    .read_error      (read_error)
);

// File: sim/csr_data_tb.sv
/*
 * Testbench for csr_data, driven by sim/csr_data_tests.txt.
 * Must be run from the project root. Inputs change 1 ns after the rising edge.
 */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_data_tb;

    localparam int RESP_TIMEOUT = 20;

    typedef logic [$clog2(`CSR_NUM_FPU_BLOCKS)-1:0] blk_idx_t;

    logic                                           clk;
    logic                                           reset;
    logic                                           write_enable;
    csr_pkg::warp_id_t                              write_wid;
    csr_pkg::csr_addr_t                             write_addr;
    csr_pkg::csr_word_t                             write_data;
    logic [`CSR_NUM_FPU_BLOCKS-1:0]                 fpu_write_enable;
    csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]    fpu_write_wid;
    csr_pkg::fflags_t [`CSR_NUM_FPU_BLOCKS-1:0]     fpu_write_fflags;
    csr_pkg::warp_id_t [`CSR_NUM_FPU_BLOCKS-1:0]    fpu_read_wid;
    csr_pkg::frm_t [`CSR_NUM_FPU_BLOCKS-1:0]        fpu_read_frm;
    csr_pkg::counter_t                              cycles;
    csr_pkg::counter_t                              instret;
    csr_pkg::warp_mask_t                            active_warps;
    csr_pkg::thread_mask_t [`CSR_NUM_WARPS-1:0]     thread_masks;
    logic                                           read_enable;
    csr_pkg::warp_id_t                              read_wid;
    csr_pkg::csr_addr_t                             read_addr;
    logic                                           read_resp_valid;
    csr_pkg::csr_word_t                             read_data;
    logic                                           read_error;

    csr_data #(.core_id(1)) csr_data_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic fail_now(input string reason);
        if (reason.len() > 0) begin
            $display("%s", reason);
        end
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            fail_now("");
        end
    endtask

    task automatic check_field_count(input int code, input int wanted, input int line_no);
        if (code != wanted) begin
            fail_now($sformatf("Malformed line %0d in the test file", line_no));
        end
    endtask

    // One clock, then drop all strobes
    task automatic step_cycle();
        @(posedge clk);
        #1;
        write_enable = 1'b0;
        fpu_write_enable = '0;
        read_enable = 1'b0;
    endtask

    task automatic wait_response(output int latency);
        latency = 0;
        while (!read_resp_valid) begin
            if (latency >= RESP_TIMEOUT) begin
                fail_now("No read response arrived within the timeout");
            end else begin
                step_cycle();
                latency++;
            end
        end
    endtask

    task automatic issue_read(input csr_pkg::warp_id_t wid, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::csr_word_t exp_data, input logic exp_err);
        int latency;
        read_enable = 1'b1;
        read_wid = wid;
        read_addr = addr;
        step_cycle();
        wait_response(latency);
        compare_value("read_latency", 64'd0, 64'(latency));
        compare_value("read_data", 64'(exp_data), 64'(read_data));
        compare_value("read_error", 64'(exp_err), 64'(read_error));
    endtask

    task automatic run_file(input int fd);
        logic [7:0]  op;
        logic [63:0] f1, f2, f3, f4;
        blk_idx_t    blk;
        int          code;
        int          ch;
        int          line_no;
        line_no = 0;
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            line_no++;
            case (op)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "W": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    check_field_count(code, 4, line_no);
                    write_enable = 1'b1;
                    write_wid = f1[$bits(write_wid)-1:0];
                    write_addr = f2[$bits(write_addr)-1:0];
                    write_data = f3[31:0];
                    if (f4 == 64'd0) begin
                        step_cycle();
                    end
                end
                "F": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    check_field_count(code, 4, line_no);
                    blk = f1[$bits(blk)-1:0];
                    fpu_write_enable[blk] = 1'b1;
                    fpu_write_wid[blk] = f2[$bits(csr_pkg::warp_id_t)-1:0];
                    fpu_write_fflags[blk] = f3[`CSR_FFLAGS_BITS-1:0];
                    if (f4 == 64'd0) begin
                        step_cycle();
                    end
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    check_field_count(code, 4, line_no);
                    cycles = f1[`CSR_CTR_BITS-1:0];
                    instret = f2[`CSR_CTR_BITS-1:0];
                    active_warps = f3[`CSR_NUM_WARPS-1:0];
                    thread_masks = f4[$bits(thread_masks)-1:0];
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    check_field_count(code, 4, line_no);
                    issue_read(f1[$bits(csr_pkg::warp_id_t)-1:0], f2[`CSR_ADDR_BITS-1:0],
                               f3[31:0], f4[0]);
                end
                "M": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    check_field_count(code, 3, line_no);
                    blk = f1[$bits(blk)-1:0];
                    fpu_read_wid[blk] = f2[$bits(csr_pkg::warp_id_t)-1:0];
                    step_cycle();
                    compare_value("fpu_read_frm", f3, 64'(fpu_read_frm[blk]));
                end
                default: begin
                    fail_now($sformatf("Unknown operation '%c' on line %0d", op, line_no));
                end
            endcase
            code = $fscanf(fd, " %c", op);
        end
    endtask

    initial begin
        int fd;
        reset = 1'b1;
        write_enable = 1'b0;
        write_wid = '0;
        write_addr = '0;
        write_data = '0;
        fpu_write_enable = '0;
        fpu_write_wid = '0;
        fpu_write_fflags = '0;
        fpu_read_wid = '0;
        cycles = '0;
        instret = '0;
        active_warps = '0;
        thread_masks = '0;
        read_enable = 1'b0;
        read_wid = '0;
        read_addr = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("sim/csr_data_tests.txt", "r");
        if (fd == 0) begin
            fail_now("Cannot open the test file sim/csr_data_tests.txt");
        end else begin
            run_file(fd);
            $fclose(fd);
            // Let the assertions see the last response
            step_cycle();
            if (csr_data_inst.checker_inst.assert_failures == 0) begin
                $display("All checks passed");
                $finish;
            end else begin
                fail_now("The bound checker reported assertion failures");
            end
        end
    end

endmodule

// File: vx_csr.f
+incdir+common
common/csr_pkg.sv
fcsr/fcsr_regfile.sv
hdl/csr_info_decode.sv
hdl/csr_read_merge.sv
hdl/csr_data.sv
sim/csr_data_checker.sv
sim/csr_data_tb.sv

// File: Makefile
# Verilator build and run of the CSR data block testbench.
# Run from the project root; any variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= csr_data_tb
FILELIST  ?= vx_csr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/csr_data_tests.txt
# Fields in hex: W wid addr data hold | F blk wid flags hold | S cycles instret warps tmasks
# R wid addr exp_data exp_err | M blk wid exp_frm   (hold 1 keeps the next line in this cycle)
R 0 003 00000000 0
R 1 001 00000000 0
R 2 002 00000000 0
R 3 003 00000000 0
R 0 f11 00000101 0
R 0 f12 00000002 0
R 0 f13 00000003 0
R 0 301 40001121 0
R 0 cc2 00000001 0
R 0 fc0 00000004 0
R 0 fc1 00000004 0
R 0 fc2 00000002 0
R 0 300 00000000 0
R 0 3b0 00000000 0
R 0 180 00000000 0
W 1 002 00000005 0
R 1 003 000000a0 0
R 0 003 00000000 0
W 2 003 000001f3 0
R 2 003 000000f3 0
R 2 002 00000007 0
R 2 001 00000013 0
W 2 300 ffffffff 0
R 2 003 000000f3 0
R 2 300 00000000 0
F 0 0 01 1
F 1 3 04 0
F 0 0 08 1
F 1 3 10 0
R 0 001 00000009 0
R 3 001 00000014 0
F 0 3 02 1
W 3 001 00000001 0
R 3 001 00000001 0
R 3 003 00000001 0
W 0 002 00000003 1
R 0 002 00000000 0
R 0 003 00000069 0
M 0 1 5
M 1 2 7
M 0 0 3
S abc12345678 123fedcba98 b 4321
R 2 cc1 00000002 0
R 2 cc4 00000003 0
R 3 cc4 00000004 0
R 0 cc3 0000000b 0
R 0 b00 12345678 0
R 0 b80 00000abc 0
R 0 b02 fedcba98 0
R 0 b82 00000123 0
R 0 7ff 00000000 1
R 1 b00 12345678 0
R 0 001 00000009 0
